/* logic/core_config.svh */
////////////////////
// Widths, stream IDs and routing mask
// Compatibility numbers and internal PPS timing
////////////////////
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Stream and settings widths
`define CORE_DATA_W        64
`define CORE_SID_W         8
`define CORE_SET_ADDR_W    8
`define CORE_SET_DATA_W    32

// Control stream IDs, compared on the low byte after masking
`define CORE_SID_MASK      8'hF0
`define CORE_R0_CTRL_SID   8'h10
`define CORE_L0_CTRL_SID   8'h40

`define CORE_COMPAT_MAJOR  16'd6
`define CORE_COMPAT_MINOR  16'd0
`define CORE_SIGNATURE     32'hACE0BA5E
`define CORE_RADIO_STATUS  8'd1     // One radio fitted

`define CORE_PPS_PERIOD    50       // Short period for simulation
`define CORE_PPS_HIGH      5

`endif

/* logic/core_bus_pkg.sv */
////////////////////
// Stream beat, packet header and settings write types
////////////////////
`default_nettype none

`include "core_config.svh"

package core_bus_pkg;

    // One word of a valid/ready stream, ready travels back separately
    typedef struct packed {
        logic [`CORE_DATA_W-1:0] data;
        logic                    last;
        logic                    valid;
    } stream_beat_t;

    // Header word of a control or response packet
    typedef struct packed {
        logic [3:0]  flags;     // Always zero here
        logic [11:0] seqnum;
        logic [15:0] length;    // Bytes
        logic [15:0] src_sid;
        logic [15:0] dst_sid;
    } cvita_hdr_t;

    typedef struct packed {
        logic                        stb;
        logic [`CORE_SET_ADDR_W-1:0] addr;
        logic [`CORE_SET_DATA_W-1:0] data;
    } set_write_t;

endpackage

`default_nettype wire

/* logic/core_regs_pkg.sv */
////////////////////
// Setting addresses, readback slots, PPS sources, processor states
////////////////////
`default_nettype none

`include "core_config.svh"

package core_regs_pkg;

    typedef enum logic [`CORE_SET_ADDR_W-1:0] {
        SR_MISC     = 16,
        SR_READBACK = 32,
        SR_GPSDO_ST = 40,
        SR_PPS_SEL  = 48
    } set_addr_e;

    typedef enum logic [1:0] {
        RB_SIGNATURE = 2'd0,
        RB_STATUS    = 2'd1,
        RB_LOCK      = 2'd2,
        RB_RESERVED  = 2'd3    // Old SPI slot, reads zero
    } rb_slot_e;

    typedef enum logic [1:0] {
        PPS_GPSDO    = 2'd0,
        PPS_EXTERNAL = 2'd1,
        PPS_INTERNAL = 2'd2,
        PPS_OFF      = 2'd3
    } pps_src_e;

    typedef enum logic [2:0] {
        ST_HEADER,
        ST_PAYLOAD,
        ST_WRITE,
        ST_RESP_HDR,
        ST_RESP_DATA
    } ctrl_state_e;

endpackage

`default_nettype wire

/* logic/ctrl_demux.sv */
////////////////////
// Control packet router, radio or local core
////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module ctrl_demux (
    input  wire                              radio_clk,
    input  wire                              bus_rst,
    input  wire core_bus_pkg::stream_beat_t  i_ctrl,
    output logic                             o_ctrl_ready,
    output core_bus_pkg::stream_beat_t       o_radio_ctrl,
    input  wire                              i_radio_ctrl_ready,
    output core_bus_pkg::stream_beat_t       o_local_ctrl,
    input  wire                              i_local_ctrl_ready
);

    core_bus_pkg::cvita_hdr_t  hdr;
    logic [`CORE_SID_W-1:0]    masked_sid;
    logic                      hdr_to_radio;
    logic                      mid_pkt_q;      // Past the first word
    logic                      route_radio_q;
    logic                      route_radio;
    logic                      xfer;

    assign hdr          = i_ctrl.data;
    assign masked_sid   = hdr.dst_sid[`CORE_SID_W-1:0] & `CORE_SID_MASK;
    assign hdr_to_radio = (masked_sid == `CORE_R0_CTRL_SID);   // Anything else is local
    assign route_radio  = mid_pkt_q ? route_radio_q : hdr_to_radio;

    assign o_ctrl_ready = route_radio ? i_radio_ctrl_ready : i_local_ctrl_ready;
    assign xfer         = i_ctrl.valid & o_ctrl_ready;

    always_comb begin
        o_radio_ctrl       = i_ctrl;
        o_radio_ctrl.valid = i_ctrl.valid & route_radio;
        o_local_ctrl       = i_ctrl;
        o_local_ctrl.valid = i_ctrl.valid & ~route_radio;
    end

    // Hold the route from the first word until the last one goes
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            mid_pkt_q     <= 1'b0;
            route_radio_q <= 1'b0;
        end else if (xfer) begin
            mid_pkt_q <= ~i_ctrl.last;
            if (!mid_pkt_q)
                route_radio_q <= hdr_to_radio;
        end
    end

endmodule

`default_nettype wire

/* logic/resp_mux.sv */
////////////////////
// Round-robin response merge, whole packets only
////////////////////
`timescale 1ns/10ps
`default_nettype none

module resp_mux (
    input  wire                              radio_clk,
    input  wire                              bus_rst,
    input  wire core_bus_pkg::stream_beat_t  i_core_resp,
    output logic                             o_core_resp_ready,
    input  wire core_bus_pkg::stream_beat_t  i_radio_resp,
    output logic                             o_radio_resp_ready,
    output core_bus_pkg::stream_beat_t       o_resp,
    input  wire                              i_resp_ready
);

    logic busy_q;         // Inside a packet
    logic grant_q;        // 0 core, 1 radio
    logic prio_q;         // Input tried first when idle
    logic pick;
    logic sel;
    logic xfer;

    // Idle choice, preferred input wins when both are valid
    always_comb begin
        if (prio_q)
            pick = i_radio_resp.valid ? 1'b1 : ~i_core_resp.valid;
        else
            pick = i_core_resp.valid ? 1'b0 : i_radio_resp.valid;
    end

    assign sel    = busy_q ? grant_q : pick;
    assign o_resp = sel ? i_radio_resp : i_core_resp;

    assign o_core_resp_ready  = ~sel & i_resp_ready;
    assign o_radio_resp_ready = sel & i_resp_ready;
    assign xfer               = o_resp.valid & i_resp_ready;

    ////////////////////
    // Grant tracking
    ////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            busy_q  <= 1'b0;
            grant_q <= 1'b0;
            prio_q  <= 1'b0;      // Core first
        end else if (xfer) begin
            grant_q <= sel;
            if (o_resp.last) begin
                busy_q <= 1'b0;
                prio_q <= ~sel;   // Other side next time
            end else begin
                busy_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/ctrl_proc.sv */
////////////////////
// Command processor, one settings write per packet plus response
////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module ctrl_proc (
    input  wire                              radio_clk,
    input  wire                              bus_rst,
    input  wire core_bus_pkg::stream_beat_t  i_cmd,
    output logic                             o_cmd_ready,
    output core_bus_pkg::set_write_t         o_set,
    input  wire [`CORE_DATA_W-1:0]           i_readback,
    output core_bus_pkg::stream_beat_t       o_core_resp,
    input  wire                              i_core_resp_ready
);

    core_regs_pkg::ctrl_state_e  state_q;
    core_bus_pkg::cvita_hdr_t    hdr_q;
    core_bus_pkg::cvita_hdr_t    resp_hdr;
    logic [`CORE_DATA_W-1:0]     payload_q;
    logic [`CORE_DATA_W-1:0]     rb_q;
    logic                        pay_seen_q;   // First payload word taken
    logic                        cmd_xfer;
    logic                        resp_xfer;

    assign o_cmd_ready = (state_q == core_regs_pkg::ST_HEADER) |
                         (state_q == core_regs_pkg::ST_PAYLOAD);
    assign cmd_xfer    = i_cmd.valid & o_cmd_ready;
    assign resp_xfer   = o_core_resp.valid & i_core_resp_ready;

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            state_q    <= core_regs_pkg::ST_HEADER;
            pay_seen_q <= 1'b0;
        end else begin
            case (state_q)
                core_regs_pkg::ST_HEADER: begin
                    if (cmd_xfer && !i_cmd.last) begin   // Lone header is dropped
                        state_q    <= core_regs_pkg::ST_PAYLOAD;
                        pay_seen_q <= 1'b0;
                    end
                end
                core_regs_pkg::ST_PAYLOAD: begin
                    if (cmd_xfer) begin
                        pay_seen_q <= 1'b1;
                        if (i_cmd.last)
                            state_q <= core_regs_pkg::ST_WRITE;
                    end
                end
                core_regs_pkg::ST_WRITE:
                    state_q <= core_regs_pkg::ST_RESP_HDR;
                core_regs_pkg::ST_RESP_HDR:
                    if (resp_xfer) state_q <= core_regs_pkg::ST_RESP_DATA;
                core_regs_pkg::ST_RESP_DATA:
                    if (resp_xfer) state_q <= core_regs_pkg::ST_HEADER;
                default:
                    state_q <= core_regs_pkg::ST_HEADER;
            endcase
        end
    end

    // Packet contents, extra payload words are ignored
    always_ff @(posedge radio_clk) begin
        if (cmd_xfer && state_q == core_regs_pkg::ST_HEADER)
            hdr_q <= i_cmd.data;
        if (cmd_xfer && state_q == core_regs_pkg::ST_PAYLOAD && !pay_seen_q)
            payload_q <= i_cmd.data;
        if (resp_xfer && state_q == core_regs_pkg::ST_RESP_HDR)
            rb_q <= i_readback;     // Write has landed by now
    end

    always_comb begin
        resp_hdr         = '0;
        resp_hdr.seqnum  = hdr_q.seqnum;
        resp_hdr.length  = 16'd16;
        resp_hdr.src_sid = hdr_q.dst_sid;
        resp_hdr.dst_sid = hdr_q.src_sid;

        o_set.stb  = (state_q == core_regs_pkg::ST_WRITE);
        o_set.addr = payload_q[39:32];
        o_set.data = payload_q[31:0];

        o_core_resp.valid = (state_q == core_regs_pkg::ST_RESP_HDR) |
                            (state_q == core_regs_pkg::ST_RESP_DATA);
        o_core_resp.last  = (state_q == core_regs_pkg::ST_RESP_DATA);
        o_core_resp.data  = o_core_resp.last ? rb_q : resp_hdr;
    end

endmodule

`default_nettype wire

/* logic/core_settings.sv */
////////////////////
// Core setting registers, lock sync, readback mux
////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module core_settings (
    input  wire                            radio_clk,
    input  wire                            bus_rst,
    input  wire core_bus_pkg::set_write_t  i_set,
    input  wire [31:0]                     i_rb_misc,
    input  wire [1:0]                      i_lock,
    output logic [`CORE_DATA_W-1:0]        o_readback,
    output logic [31:0]                    o_misc_outs,
    output core_regs_pkg::pps_src_e        o_pps_src
);

    core_regs_pkg::set_addr_e  addr;
    core_regs_pkg::rb_slot_e   rb_sel_q;
    logic [7:0]                gpsdo_st_q;
    logic [1:0]                lock_q1;
    logic [1:0]                lock_q2;

    assign addr = core_regs_pkg::set_addr_e'(i_set.addr);

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_misc_outs <= '0;
            rb_sel_q    <= core_regs_pkg::RB_SIGNATURE;
            o_pps_src   <= core_regs_pkg::PPS_GPSDO;
        end else if (i_set.stb) begin
            case (addr)
                core_regs_pkg::SR_MISC:     o_misc_outs <= i_set.data;
                core_regs_pkg::SR_READBACK:
                    rb_sel_q <= core_regs_pkg::rb_slot_e'(i_set.data[1:0]);
                core_regs_pkg::SR_PPS_SEL:
                    o_pps_src <= core_regs_pkg::pps_src_e'(i_set.data[1:0]);
                default: ;                  // Unknown address
            endcase
        end
    end

    // GPSDO status survives a bus reset
    always_ff @(posedge radio_clk) begin
        if (i_set.stb && addr == core_regs_pkg::SR_GPSDO_ST)
            gpsdo_st_q <= i_set.data[7:0];
    end

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            lock_q1 <= '0;
            lock_q2 <= '0;
        end else begin
            lock_q1 <= i_lock;
            lock_q2 <= lock_q1;
        end
    end

    always_comb begin
        case (rb_sel_q)
            core_regs_pkg::RB_SIGNATURE:
                o_readback = {`CORE_SIGNATURE, `CORE_COMPAT_MAJOR, `CORE_COMPAT_MINOR};
            core_regs_pkg::RB_STATUS:
                o_readback = {16'h0, `CORE_RADIO_STATUS, gpsdo_st_q, i_rb_misc};
            core_regs_pkg::RB_LOCK:
                o_readback = {62'h0, lock_q2};
            default:
                o_readback = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/pps_select.sv */
////////////////////
// PPS generator, synchronizers and source select
////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module pps_select (
    input  wire                           radio_clk,
    input  wire                           bus_rst,
    input  wire                           i_pps_gpsdo,
    input  wire                           i_pps_ext,
    input  wire core_regs_pkg::pps_src_e  i_pps_src,
    output logic                          o_pps
);

    localparam int CNT_W = $clog2(`CORE_PPS_PERIOD);

    logic [CNT_W-1:0] cnt_q;
    logic             int_pps;
    logic [2:0]       sync_q1;    // {internal, external, gpsdo}
    logic [2:0]       sync_q2;

    assign int_pps = (cnt_q < CNT_W'(`CORE_PPS_HIGH));   // High at start of period

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            cnt_q   <= '0;
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            if (cnt_q == CNT_W'(`CORE_PPS_PERIOD - 1))
                cnt_q <= '0;
            else
                cnt_q <= cnt_q + CNT_W'(1);
            sync_q1 <= {int_pps, i_pps_ext, i_pps_gpsdo};
            sync_q2 <= sync_q1;
        end
    end

    always_comb begin
        case (i_pps_src)
            core_regs_pkg::PPS_GPSDO:    o_pps = sync_q2[0];
            core_regs_pkg::PPS_EXTERNAL: o_pps = sync_q2[1];
            core_regs_pkg::PPS_INTERNAL: o_pps = sync_q2[2];
            default:                     o_pps = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/core_ctrl_top.sv */
////////////////////
// Control core top level
////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module core_ctrl_top (
    input  wire                              radio_clk,
    input  wire                              bus_rst,
    input  wire core_bus_pkg::stream_beat_t  i_ctrl,
    output logic                             o_ctrl_ready,
    output core_bus_pkg::stream_beat_t       o_resp,
    input  wire                              i_resp_ready,
    output core_bus_pkg::stream_beat_t       o_radio_ctrl,
    input  wire                              i_radio_ctrl_ready,
    input  wire core_bus_pkg::stream_beat_t  i_radio_resp,
    output logic                             o_radio_resp_ready,
    input  wire [31:0]                       i_rb_misc,
    input  wire [1:0]                        i_lock,
    input  wire                              i_pps_gpsdo,
    input  wire                              i_pps_ext,
    output logic [31:0]                      o_misc_outs,
    output logic                             o_pps
);

    core_bus_pkg::stream_beat_t  local_ctrl;
    logic                        local_ctrl_ready;
    core_bus_pkg::stream_beat_t  core_resp;
    logic                        core_resp_ready;
    core_bus_pkg::set_write_t    set_wr;
    logic [`CORE_DATA_W-1:0]     readback;
    core_regs_pkg::pps_src_e     pps_src;

    ////////////////////
    // Command path
    ////////////////////
    ctrl_demux ctrl_demux_inst (
        .radio_clk          (radio_clk),
        .bus_rst            (bus_rst),
        .i_ctrl             (i_ctrl),
        .o_ctrl_ready       (o_ctrl_ready),
        .o_radio_ctrl       (o_radio_ctrl),
        .i_radio_ctrl_ready (i_radio_ctrl_ready),
        .o_local_ctrl       (local_ctrl),
        .i_local_ctrl_ready (local_ctrl_ready)
    );

    ctrl_proc ctrl_proc_inst (
        .radio_clk         (radio_clk),
        .bus_rst           (bus_rst),
        .i_cmd             (local_ctrl),
        .o_cmd_ready       (local_ctrl_ready),
        .o_set             (set_wr),
        .i_readback        (readback),
        .o_core_resp       (core_resp),
        .i_core_resp_ready (core_resp_ready)
    );

    core_settings core_settings_inst (
        .radio_clk   (radio_clk),
        .bus_rst     (bus_rst),
        .i_set       (set_wr),
        .i_rb_misc   (i_rb_misc),
        .i_lock      (i_lock),
        .o_readback  (readback),
        .o_misc_outs (o_misc_outs),
        .o_pps_src   (pps_src)
    );

    pps_select pps_select_inst (
        .radio_clk   (radio_clk),
        .bus_rst     (bus_rst),
        .i_pps_gpsdo (i_pps_gpsdo),
        .i_pps_ext   (i_pps_ext),
        .i_pps_src   (pps_src),
        .o_pps       (o_pps)
    );

    // Responses from core and radio onto one stream
    resp_mux resp_mux_inst (
        .radio_clk          (radio_clk),
        .bus_rst            (bus_rst),
        .i_core_resp        (core_resp),
        .o_core_resp_ready  (core_resp_ready),
        .i_radio_resp       (i_radio_resp),
        .o_radio_resp_ready (o_radio_resp_ready),
        .o_resp             (o_resp),
        .i_resp_ready       (i_resp_ready)
    );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
////////////////////
// Testbench clock and reset source
////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic radio_clk,
    output logic bus_rst
);

    initial begin
        radio_clk = 1'b0;
        forever #2 radio_clk = ~radio_clk;    // 4 ns period
    end

    initial begin
        bus_rst = 1'b1;
        repeat (16) @(posedge radio_clk);
        @(negedge radio_clk);
        bus_rst = 1'b0;
    end

endmodule

`default_nettype wire

/* verification/tb_core_ctrl.sv */
////////////////////
// Table-driven testbench for the control core
// Routing, settings readback, response merge and PPS select
////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module tb_core_ctrl;

    localparam int NUM_TESTS    = 9;
    localparam int TEST_CYCLES  = 200;
    localparam int RESET_CYCLES = 17;
    localparam int CLK_NS       = 4;

    localparam logic [2:0]  K_CORE    = 3'd0;   // Plain core command
    localparam logic [2:0]  K_RADIO   = 3'd1;
    localparam logic [2:0]  K_PPS_EXT = 3'd2;
    localparam logic [2:0]  K_PPS_INT = 3'd3;
    localparam logic [2:0]  K_PPS_OFF = 3'd4;

    localparam logic [7:0]  A_MISC     = 8'd16;
    localparam logic [7:0]  A_READBACK = 8'd32;
    localparam logic [7:0]  A_GPSDO_ST = 8'd40;
    localparam logic [7:0]  A_PPS_SEL  = 8'd48;

    localparam logic [15:0] TB_SID     = 16'h0001;
    localparam logic [15:0] L0_SID     = 16'h0040;
    localparam logic [63:0] RADIO_WORD = 64'h0123_4567_89AB_CDEF;
    localparam logic [63:0] SIG_WORD   = 64'hACE0_BA5E_0006_0000;   // Signature, major 6, minor 0

    typedef struct packed {
        logic [2:0]  kind;
        logic [15:0] dst_sid;
        logic [11:0] seq;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] rb_misc;
        logic [1:0]  lock;
        logic [63:0] exp_rb;
        logic [31:0] exp_misc;
    } test_vec_t;

    logic                        radio_clk;
    logic                        bus_rst;
    core_bus_pkg::stream_beat_t  i_ctrl;
    core_bus_pkg::stream_beat_t  o_resp;
    core_bus_pkg::stream_beat_t  o_radio_ctrl;
    core_bus_pkg::stream_beat_t  i_radio_resp;
    logic                        o_ctrl_ready;
    logic                        i_resp_ready;
    logic                        i_radio_ctrl_ready;
    logic                        o_radio_resp_ready;
    logic [31:0]                 i_rb_misc;
    logic [31:0]                 o_misc_outs;
    logic [1:0]                  i_lock;
    logic                        i_pps_gpsdo;
    logic                        i_pps_ext;
    logic                        o_pps;

    test_vec_t    tests [NUM_TESTS];
    string        names [NUM_TESTS];
    string        cur_name = "reset_state";
    logic [64:0]  core_q  [$];    // {last, data} per response word
    logic [64:0]  radio_q [$];
    logic [64:0]  rctl_q  [$];
    int           test_errors = 0;
    int           passed = 0;
    int           failed = 0;
    logic         in_pkt = 1'b0;
    logic         pkt_src = 1'b0;  // 1 for radio

    tb_clock tb_clock_inst (
        .radio_clk (radio_clk),
        .bus_rst   (bus_rst)
    );

    core_ctrl_top core_ctrl_top_inst (
        .radio_clk          (radio_clk),
        .bus_rst            (bus_rst),
        .i_ctrl             (i_ctrl),
        .o_ctrl_ready       (o_ctrl_ready),
        .o_resp             (o_resp),
        .i_resp_ready       (i_resp_ready),
        .o_radio_ctrl       (o_radio_ctrl),
        .i_radio_ctrl_ready (i_radio_ctrl_ready),
        .i_radio_resp       (i_radio_resp),
        .o_radio_resp_ready (o_radio_resp_ready),
        .i_rb_misc          (i_rb_misc),
        .i_lock             (i_lock),
        .i_pps_gpsdo        (i_pps_gpsdo),
        .i_pps_ext          (i_pps_ext),
        .o_misc_outs        (o_misc_outs),
        .o_pps              (o_pps)
    );

    task automatic check_val(input string what, input logic [64:0] exp,
                             input logic [64:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    // Drives a two-word packet on i_ctrl or i_radio_resp
    task automatic send_packet(input logic to_radio_resp, input logic [63:0] w0,
                               input logic [63:0] w1);
        core_bus_pkg::stream_beat_t beat;
        int w;
        logic rdy;
        for (w = 0; w < 2; w++) begin
            @(negedge radio_clk);
            beat.data  = (w == 0) ? w0 : w1;
            beat.last  = (w == 1);
            beat.valid = 1'b1;
            if (to_radio_resp)
                i_radio_resp = beat;
            else
                i_ctrl = beat;
            #1;
            rdy = to_radio_resp ? o_radio_resp_ready : o_ctrl_ready;
            while (!rdy) begin
                @(negedge radio_clk);
                #1;
                rdy = to_radio_resp ? o_radio_resp_ready : o_ctrl_ready;
            end
        end
        @(negedge radio_clk);
        if (to_radio_resp)
            i_radio_resp = '0;
        else
            i_ctrl = '0;
    endtask

    task automatic wait_words(input int n_core, input int n_radio, input int n_rctl);
        int cnt;
        cnt = 0;
        while ((core_q.size() < n_core || radio_q.size() < n_radio ||
                rctl_q.size() < n_rctl) && cnt < TEST_CYCLES) begin
            @(negedge radio_clk);
            cnt++;
        end
        assert (cnt < TEST_CYCLES) else begin
            $display("%s: expected packets did not arrive in time", cur_name);
            test_errors++;
        end
    endtask

    ////////////////////
    // PPS checks
    ////////////////////
    task automatic check_pps_ext();
        logic        hist [32];
        logic [31:0] r;
        int          k;
        for (k = 0; k < 32; k++) begin
            @(negedge radio_clk);
            r         = $urandom;
            hist[k]   = r[0];
            i_pps_ext = hist[k];
            #1;
            if (k >= 2)
                check_val("pps ext delay", {64'h0, hist[k-2]}, {64'h0, o_pps});
        end
        @(negedge radio_clk);
        i_pps_ext = 1'b0;
    endtask

    task automatic check_pps_int();
        int   k;
        int   last_rise;
        int   rises;
        logic prev;
        last_rise = -1;
        rises     = 0;
        @(negedge radio_clk);
        #1;
        prev = o_pps;
        for (k = 0; k < 3 * `CORE_PPS_PERIOD + 10; k++) begin
            @(negedge radio_clk);
            #1;
            if (o_pps && !prev) begin
                if (last_rise >= 0)
                    check_val("pps period", 65'(`CORE_PPS_PERIOD), 65'(k - last_rise));
                last_rise = k;
                rises++;
            end
            prev = o_pps;
        end
        assert (rises >= 2) else begin
            $display("%s: internal PPS did not pulse", cur_name);
            test_errors++;
        end
    endtask

    task automatic check_pps_off();
        int k;
        int highs;
        highs = 0;
        for (k = 0; k < 60; k++) begin
            @(negedge radio_clk);
            i_pps_ext = ~i_pps_ext;     // Busy input that must not leak through
            #1;
            if (o_pps)
                highs++;
        end
        i_pps_ext = 1'b0;
        check_val("pps high cycles", 65'h0, 65'(highs));
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("%-14s ok", cur_name);
            passed++;
        end else begin
            $display("%-14s failed with %0d errors", cur_name, test_errors);
            failed++;
        end
        test_errors = 0;
    endtask

    task automatic run_test(input int idx);
        test_vec_t   t;
        logic [63:0] cmd_hdr;
        logic [63:0] payload;
        logic [63:0] resp_hdr;
        logic [63:0] radio_hdr;
        t        = tests[idx];
        cur_name = names[idx];
        @(negedge radio_clk);
        i_rb_misc = t.rb_misc;
        i_lock    = t.lock;
        repeat (4) @(negedge radio_clk);   // Lock bits through the synchronizer
        cmd_hdr   = {4'h0, t.seq, 16'd16, TB_SID, t.dst_sid};
        payload   = {24'h0, t.addr, t.data};
        resp_hdr  = {4'h0, t.seq, 16'd16, t.dst_sid, TB_SID};
        radio_hdr = {4'h0, t.seq, 16'd16, t.dst_sid, TB_SID};
        if (t.kind == K_RADIO) begin
            // Local read with an unused address so both responses compete
            resp_hdr = {4'h0, t.seq, 16'd16, L0_SID, TB_SID};
            fork
                begin
                    send_packet(1'b0, cmd_hdr, payload);
                    send_packet(1'b0, {4'h0, t.seq, 16'd16, TB_SID, L0_SID}, 64'h0);
                end
                begin
                    repeat (6) @(negedge radio_clk);
                    send_packet(1'b1, radio_hdr, RADIO_WORD);
                end
            join
            wait_words(2, 2, 2);
            check_val("radio ctrl header", {1'b0, cmd_hdr}, rctl_q.pop_front());
            check_val("radio ctrl payload", {1'b1, payload}, rctl_q.pop_front());
            check_val("radio resp header", {1'b0, radio_hdr}, radio_q.pop_front());
            check_val("radio resp data", {1'b1, RADIO_WORD}, radio_q.pop_front());
        end else begin
            send_packet(1'b0, cmd_hdr, payload);
            wait_words(2, 0, 0);
        end
        check_val("resp header", {1'b0, resp_hdr}, core_q.pop_front());
        check_val("readback", {1'b1, t.exp_rb}, core_q.pop_front());
        check_val("misc outs", {33'h0, t.exp_misc}, {33'h0, o_misc_outs});
        case (t.kind)
            K_PPS_EXT: check_pps_ext();
            K_PPS_INT: check_pps_int();
            K_PPS_OFF: check_pps_off();
            default: ;
        endcase
        end_test();
    endtask

    // Response monitor, sampled between the falling and rising edge
    always @(negedge radio_clk) begin
        #1;
        if (o_resp.valid && i_resp_ready) begin
            if (in_pkt) begin
                assert (o_radio_resp_ready == pkt_src) else begin
                    $display("%s: core and radio responses interleaved", cur_name);
                    test_errors++;
                end
            end
            pkt_src = o_radio_resp_ready;
            in_pkt  = !o_resp.last;
            if (o_radio_resp_ready)
                radio_q.push_back({o_resp.last, o_resp.data});
            else
                core_q.push_back({o_resp.last, o_resp.data});
        end
        if (o_radio_ctrl.valid && i_radio_ctrl_ready)
            rctl_q.push_back({o_radio_ctrl.last, o_radio_ctrl.data});
    end

    // Random back-pressure on both outgoing streams
    initial begin
        i_resp_ready       = 1'b0;
        i_radio_ctrl_ready = 1'b0;
        forever begin
            @(negedge radio_clk);
            i_resp_ready       = (($urandom % 4) != 0);
            i_radio_ctrl_ready = (($urandom % 4) != 0);
        end
    end

    initial begin
        #((NUM_TESTS * TEST_CYCLES + RESET_CYCLES) * CLK_NS);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h5fce));
        i_ctrl       = '0;
        i_radio_resp = '0;
        i_rb_misc    = '0;
        i_lock       = '0;
        i_pps_gpsdo  = 1'b0;
        i_pps_ext    = 1'b0;

        // kind, dst sid, seq, addr, data, rb_misc, lock, readback, misc outs
        tests[0] = '{K_CORE, 16'h0040, 12'd1, A_MISC, 32'hDEADBEEF, 32'h0, 2'b00,
                     SIG_WORD, 32'hDEADBEEF};
        tests[1] = '{K_CORE, 16'h0041, 12'd2, A_GPSDO_ST, 32'h5A, 32'h0, 2'b00,
                     SIG_WORD, 32'hDEADBEEF};
        tests[2] = '{K_CORE, 16'h0040, 12'd3, A_READBACK, 32'd1, 32'h12345678, 2'b00,
                     64'h0000_015A_1234_5678, 32'hDEADBEEF};
        tests[3] = '{K_CORE, 16'h0040, 12'd4, A_READBACK, 32'd2, 32'h0, 2'b10,
                     64'h2, 32'hDEADBEEF};
        tests[4] = '{K_CORE, 16'h0083, 12'd5, A_MISC, 32'hA5, 32'h0, 2'b01, 64'h1, 32'hA5};
        tests[5] = '{K_RADIO, 16'h0012, 12'd6, A_MISC, 32'hFFFF0000, 32'h0, 2'b01,
                     64'h1, 32'hA5};
        tests[6] = '{K_PPS_EXT, 16'h0040, 12'd7, A_PPS_SEL, 32'd1, 32'h0, 2'b01, 64'h1, 32'hA5};
        tests[7] = '{K_PPS_INT, 16'h0040, 12'd8, A_PPS_SEL, 32'd2, 32'h0, 2'b01, 64'h1, 32'hA5};
        tests[8] = '{K_PPS_OFF, 16'h0040, 12'd9, A_PPS_SEL, 32'd3, 32'h0, 2'b01, 64'h1, 32'hA5};
        names = '{"misc_sig", "gpsdo_st", "status", "lock", "other_local",
                  "radio_route", "pps_ext", "pps_int", "pps_off"};

        @(negedge radio_clk);
        while (bus_rst)
            @(negedge radio_clk);
        #1;
        check_val("misc outs", 65'h0, {33'h0, o_misc_outs});
        check_val("resp valid", 65'h0, {64'h0, o_resp.valid});
        check_val("radio ctrl valid", 65'h0, {64'h0, o_radio_ctrl.valid});
        check_val("pps", 65'h0, {64'h0, o_pps});
        end_test();

        for (int i = 0; i < NUM_TESTS; i++)
            run_test(i);

        $display("Tests run: %0d, passed: %0d, failed: %0d", passed + failed, passed, failed);
        if (failed == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+logic
logic/core_bus_pkg.sv
logic/core_regs_pkg.sv
logic/ctrl_demux.sv
logic/resp_mux.sv
logic/ctrl_proc.sv
logic/core_settings.sv
logic/pps_select.sv
logic/core_ctrl_top.sv
verification/tb_clock.sv
verification/tb_core_ctrl.sv

/* run.sh */
#!/bin/sh
# Build and run the control core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_core_ctrl -f all.f -o sim_core_ctrl

out=$(./obj_dir/sim_core_ctrl)
echo "$out"

# A missing pass line makes grep, and so the script, fail
echo "$out" | grep -q "^All tests passed$"
